/* design/sens_pkg.sv */
// sensor pixel input package
// shared sizes, sample word type and host command word views
`default_nettype none

package sens_pkg;

    localparam int LANES       = 4;                      // pixel lanes
    localparam int PHASES      = 4;                      // oversampled phases per ipclk
    localparam int TAP_W       = 4;                      // quarter-phase tap, 0..15
    localparam int HIST_WORDS  = 5;                      // max tap reach plus current word
    localparam int CFG_CREDITS = 4;                      // command fifo depth = host credits
    localparam int CMD_W       = 16;                     // host command word
    localparam int QUAD_W      = $clog2(PHASES);         // quadrant select
    localparam int HIST_W      = HIST_WORDS * PHASES;    // flattened sample history
    localparam int CFG_PTR_W   = $clog2(CFG_CREDITS);    // fifo pointers
    localparam int CFG_CNT_W   = $clog2(CFG_CREDITS + 1); // fifo occupancy

    // four phase samples of one lane, bit 0 earliest
    typedef logic [PHASES-1:0] samp_word_t;

    typedef enum logic [1:0] {
        OP_NOP      = 2'd0,                              // no action, credit only
        OP_SET_TAP  = 2'd1,                              // stage a tap
        OP_LD_TAP   = 2'd2,                              // staged -> active
        OP_SET_QUAD = 2'd3                               // load quadrant
    } cfg_op_t;

    typedef struct packed {
        cfg_op_t                          op;
        logic [LANES-1:0]                 lane_mask;
        logic [CMD_W-2-LANES-TAP_W-1:0]   rsvd;         // 6 bits
        logic [TAP_W-1:0]                 tap;
    } cfg_tap_t;

    typedef struct packed {
        cfg_op_t                          op;
        logic [LANES-1:0]                 lane_mask;
        logic [CMD_W-2-LANES-QUAD_W-1:0]  rsvd;         // 8 bits
        logic [QUAD_W-1:0]                quadrant;
    } cfg_quad_t;

    // one command word, read as tap or quadrant layout by opcode
    typedef union packed {
        cfg_tap_t  t;
        cfg_quad_t q;
    } cfg_cmd_u;

endpackage

`default_nettype wire

/* design/pxd_cfg_if.sv */
// pixel lane configuration bus
// decoded command pulses and payload from the delay controller to the lanes
`timescale 1ns/1ps
`default_nettype none

interface pxd_cfg_if;
    import sens_pkg::*;

    logic [LANES-1:0]  lane_sel;     // lanes addressed by current pulse
    logic              tap_set;      // stage tap, one cycle
    logic              tap_ld;       // staged tap becomes active, one cycle
    logic [TAP_W-1:0]  tap;          // tap value for tap_set
    logic              quad_we;      // quadrant write, one cycle
    logic [QUAD_W-1:0] quadrant;     // quadrant value for quad_we

    modport ctrl (
        output lane_sel,
        output tap_set,
        output tap_ld,
        output tap,
        output quad_we,
        output quadrant
    );

    modport lane (
        input lane_sel,
        input tap_set,
        input tap_ld,
        input tap,
        input quad_we,
        input quadrant
    );

endinterface

`default_nettype wire

/* design/pxd_delay_line.sv */
// pixel lane delay line
// keeps recent sample words and picks a four-sample window d quarter-phases back,
// with a staged tap that only takes effect on a load pulse
`timescale 1ns/1ps
`default_nettype none

module pxd_delay_line (
    input  logic                       ipclk,
    input  logic                       irst,
    input  logic                       sel,       // this lane addressed
    input  logic                       tap_set,   // stage pulse
    input  logic                       tap_ld,    // load pulse
    input  logic [sens_pkg::TAP_W-1:0] tap,
    input  sens_pkg::samp_word_t       samp,      // newest word
    output sens_pkg::samp_word_t       win        // delayed window, registered
);
    import sens_pkg::*;

    samp_word_t        hist [0:HIST_WORDS-2];     // past words, [0] is previous cycle
    logic [HIST_W-1:0] flat;                      // oldest at bit 0, samp on top
    logic [TAP_W-1:0]  tap_stg;                   // staged tap
    logic [TAP_W-1:0]  tap_act;                   // tap in use

    // history starts at zero so early windows read as idle
    always_ff @(posedge ipclk) begin
        if (irst) begin
            for (int j = 0; j < HIST_WORDS - 1; j++) begin
                hist[j] <= '0;
            end
        end else begin
            hist[0] <= samp;
            for (int j = 1; j < HIST_WORDS - 1; j++) begin
                hist[j] <= hist[j-1];                 // age by one word
            end
        end
    end

    always_comb begin
        flat[HIST_W-1 -: PHASES] = samp;              // current word on top
        for (int j = 0; j < HIST_WORDS - 1; j++) begin
            flat[(HIST_WORDS-2-j)*PHASES +: PHASES] = hist[j];
        end
    end

    // two-step tap update, stage then load
    always_ff @(posedge ipclk) begin
        if (irst) begin
            tap_stg <= '0;
            tap_act <= '0;
        end else begin
            if (tap_set && sel) begin
                tap_stg <= tap;
            end
            if (tap_ld && sel) begin
                tap_act <= tap_stg;                   // applies on next window
            end
        end
    end

    // window bit i = stream element 4m+i-d, m = current word
    always_ff @(posedge ipclk) begin
        if (irst) begin
            win <= '0;
        end else begin
            win <= flat[(HIST_W - PHASES) - int'(tap_act) +: PHASES];
        end
    end

    // decoder never issues stage and load together
    a_set_ld_excl: assert property (@(posedge ipclk) disable iff (irst)
        !(tap_set && tap_ld))
        else $error("tap_set and tap_ld in the same cycle");

endmodule

`default_nettype wire

/* design/pxd_lane.sv */
// one pixel data lane
// delay line followed by a quadrant select that registers one bit per cycle
`timescale 1ns/1ps
`default_nettype none

module pxd_lane #(
    parameter int LANE = 0                     // lane index, below LANES
) (
    input  logic                 ipclk,
    input  logic                 irst,
    pxd_cfg_if.lane              cfg,
    input  sens_pkg::samp_word_t samp,
    output logic                 pxd_in        // registered pixel bit
);
    import sens_pkg::*;

    logic              sel;                    // own lane_sel bit
    logic [QUAD_W-1:0] quad;                   // 90-degree phase pick
    samp_word_t        win;                    // window from delay line

    assign sel = cfg.lane_sel[LANE];

    pxd_delay_line i_delay_line (
        .ipclk   (ipclk),
        .irst    (irst),
        .sel     (sel),
        .tap_set (cfg.tap_set),
        .tap_ld  (cfg.tap_ld),
        .tap     (cfg.tap),
        .samp    (samp),
        .win     (win)
    );

    always_ff @(posedge ipclk) begin
        if (irst) begin
            quad <= '0;
        end else if (cfg.quad_we && sel) begin
            quad <= cfg.quadrant;              // new phase from next cycle
        end
    end

    // second pipeline stage, total two cycles from samp
    always_ff @(posedge ipclk) begin
        if (irst) begin
            pxd_in <= 1'b0;
        end else begin
            pxd_in <= win[quad];
        end
    end

endmodule

`default_nettype wire

/* design/pxd_dly_ctrl.sv */
// delay and quadrant command controller
// buffers host command words under credit flow control, pops one per cycle
// and turns each into registered pulses on the lane configuration bus
`timescale 1ns/1ps
`default_nettype none

module pxd_dly_ctrl (
    input  logic               ipclk,
    input  logic               irst,
    input  logic               cfg_valid,    // host write, spends a credit
    input  sens_pkg::cfg_cmd_u cfg_word,
    output logic               cfg_credit,   // one credit back per pulse
    pxd_cfg_if.ctrl            cfg
);
    import sens_pkg::*;

    cfg_cmd_u               mem [0:CFG_CREDITS-1];  // command storage
    logic [CFG_PTR_W-1:0]   wr_ptr;
    logic [CFG_PTR_W-1:0]   rd_ptr;
    logic [CFG_CNT_W-1:0]   count;                  // entries held
    logic                   pop;
    logic                   full;
    cfg_cmd_u               head;                   // oldest entry

    assign full       = (count == CFG_CNT_W'(CFG_CREDITS));
    assign pop        = (count != '0);              // drain every cycle
    assign cfg_credit = pop;                        // buffering ends at pop
    assign head       = mem[rd_ptr];

    always_ff @(posedge ipclk) begin
        if (cfg_valid) begin
            mem[wr_ptr] <= cfg_word;
        end
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge ipclk) begin
        if (irst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (cfg_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({cfg_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;            // idle or write+pop
            endcase
        end
    end

    // pulses one cycle after the pop
    always_ff @(posedge ipclk) begin
        if (irst) begin
            cfg.tap_set <= 1'b0;
            cfg.tap_ld  <= 1'b0;
            cfg.quad_we <= 1'b0;
        end else begin
            cfg.tap_set <= 1'b0;
            cfg.tap_ld  <= 1'b0;
            cfg.quad_we <= 1'b0;
            if (pop) begin
                case (head.t.op)
                    OP_SET_TAP:  cfg.tap_set <= 1'b1;
                    OP_LD_TAP:   cfg.tap_ld  <= 1'b1;
                    OP_SET_QUAD: cfg.quad_we <= 1'b1;
                    default:     ;                  // nop returns a credit only
                endcase
            end
        end
    end

    // payload registered with the pulse and only meaningful alongside it
    always_ff @(posedge ipclk) begin
        if (pop) begin
            cfg.lane_sel <= head.t.lane_mask;
            cfg.tap      <= head.t.tap;             // tap layout
            cfg.quadrant <= head.q.quadrant;        // quadrant layout
        end
    end

    // host writes only while it holds a credit so the fifo never overflows
    a_no_full_wr: assert property (@(posedge ipclk) disable iff (irst)
        cfg_valid |-> !full)
        else $error("command write with no credit left");

    a_one_pulse: assert property (@(posedge ipclk) disable iff (irst)
        $onehot0({cfg.tap_set, cfg.tap_ld, cfg.quad_we}))
        else $error("more than one config pulse");

endmodule

`default_nettype wire

/* design/sens_pxd_in.sv */
// sensor pixel data input top
// command controller driving four pixel lanes over the configuration bus
`timescale 1ns/1ps
`default_nettype none

module sens_pxd_in (
    input  logic                                            ipclk,
    input  logic                                            irst,
    input  logic                                            cfg_valid,
    input  logic [sens_pkg::CMD_W-1:0]                      cfg_word,
    output logic                                            cfg_credit,
    input  logic [sens_pkg::LANES*sens_pkg::PHASES-1:0]     samp,      // lane k at k*4
    output logic [sens_pkg::LANES-1:0]                      pxd_in
);
    import sens_pkg::*;

    pxd_cfg_if cfg_bus ();                              // controller -> lanes

    pxd_dly_ctrl i_dly_ctrl (
        .ipclk      (ipclk),
        .irst       (irst),
        .cfg_valid  (cfg_valid),
        .cfg_word   (cfg_word),
        .cfg_credit (cfg_credit),
        .cfg        (cfg_bus)
    );

    // one lane per sample word
    for (genvar k = 0; k < LANES; k++) begin : g_lane
        pxd_lane #(
            .LANE (k)
        ) i_lane (
            .ipclk  (ipclk),
            .irst   (irst),
            .cfg    (cfg_bus),
            .samp   (samp[k*PHASES +: PHASES]),
            .pxd_in (pxd_in[k])
        );
    end

endmodule

`default_nettype wire

/* tests/tb_pxd_model.svh */
// pixel input reference model
// per-lane sample history, staged and active taps and quadrants,
// predicts pxd_in from the stream index rule
`ifndef TB_PXD_MODEL_SVH
`define TB_PXD_MODEL_SVH

localparam int MDL_AGES = 8;                       // words kept, deepest reach is 6 back

samp_word_t        mdl_hist [LANES][MDL_AGES];     // [k][0] is the newest driven word
logic [TAP_W-1:0]  mdl_stg  [LANES];               // staged taps
logic [TAP_W-1:0]  mdl_act  [LANES];               // active taps
logic [QUAD_W-1:0] mdl_quad [LANES];               // quadrants

// history before reset release reads as zero
function automatic void model_reset();
    for (int k = 0; k < LANES; k++) begin
        for (int a = 0; a < MDL_AGES; a++) begin
            mdl_hist[k][a] = '0;
        end
        mdl_stg[k]  = '0;
        mdl_act[k]  = '0;
        mdl_quad[k] = '0;
    end
endfunction

function automatic void model_push(input logic [LANES*PHASES-1:0] words);
    for (int k = 0; k < LANES; k++) begin
        for (int a = MDL_AGES - 1; a > 0; a--) begin
            mdl_hist[k][a] = mdl_hist[k][a-1];     // age by one word
        end
        mdl_hist[k][0] = words[k*PHASES +: PHASES];
    end
endfunction

// op sits in [15:14], lane mask in [13:10], tap in [3:0] and quadrant in [1:0]
function automatic void model_cmd(input logic [CMD_W-1:0] cmd);
    logic [1:0]       op;
    logic [LANES-1:0] mask;
    op   = cmd[CMD_W-1 -: 2];
    mask = cmd[CMD_W-3 -: LANES];
    for (int k = 0; k < LANES; k++) begin
        if (mask[k]) begin
            case (op)
                OP_SET_TAP:  mdl_stg[k]  = cmd[TAP_W-1:0];
                OP_LD_TAP:   mdl_act[k]  = mdl_stg[k];     // staged becomes active
                OP_SET_QUAD: mdl_quad[k] = cmd[QUAD_W-1:0];
                default:     ;                             // nop
            endcase
        end
    end
endfunction

// element 4*m + q - d where m is the word driven two edges before the newest
function automatic logic [LANES-1:0] model_predict();
    logic [LANES-1:0] exp;
    int               back;                        // samples behind bit 0 of newest word
    int               age;
    int               bit_i;
    for (int k = 0; k < LANES; k++) begin
        back   = 2*PHASES - int'(mdl_quad[k]) + int'(mdl_act[k]);
        age    = (back + PHASES - 1) / PHASES;
        bit_i  = age*PHASES - back;
        exp[k] = mdl_hist[k][age][bit_i];
    end
    return exp;
endfunction

`endif

/* tests/tb_sens_pxd_in.sv */
// testbench for the sensor pixel data input block
// random sample words and host commands under credit flow control,
// outputs checked against a reference model once configuration has settled
`timescale 1ns/1ps
`default_nettype none

module tb_sens_pxd_in;
    import sens_pkg::*;

    `include "tb_pxd_model.svh"

    localparam int SETTLE  = 4;                   // quiet cycles before data is compared
    localparam int TIMEOUT = 200;                 // cycles allowed for credits to return

    logic                    ipclk;
    logic                    irst;
    logic                    cfg_valid;
    logic [CMD_W-1:0]        cfg_word;
    logic                    cfg_credit;
    logic [LANES*PHASES-1:0] samp;
    logic [LANES-1:0]        pxd_in;

    logic rst_req;                                // irst value for the next edge
    int   credits;                                // host side credit count
    int   credit_pulses;                          // pulses since last clear
    int   quiet;                                  // cycles with nothing outstanding
    int   checks;
    int   data_errs;
    int   credit_errs;
    int   timeouts;

    sens_pxd_in i_sens_pxd_in (
        .ipclk      (ipclk),
        .irst       (irst),
        .cfg_valid  (cfg_valid),
        .cfg_word   (cfg_word),
        .cfg_credit (cfg_credit),
        .samp       (samp),
        .pxd_in     (pxd_in)
    );

    always #50 ipclk = ~ipclk;                    // 100 ns period

    task automatic check_pxd(input string name, input logic [LANES-1:0] exp,
                             input logic [LANES-1:0] act);
        checks++;
        if (act !== exp) begin
            data_errs++;
            $display("FAILED %s: expected %b actual %b at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_credits(input string name, input int exp, input int act);
        if (act != exp) begin
            credit_errs++;
            $display("FAILED %s: expected %0d actual %0d at %0t", name, exp, act, $time);
        end
    endtask

    // drive on the rising edge and observe on the falling edge
    task automatic run_cycle(input string name, input logic send, input logic [CMD_W-1:0] cmd);
        logic [31:0]             r;
        logic [LANES*PHASES-1:0] words;
        @(posedge ipclk);
        r     = $urandom;
        words = r[LANES*PHASES-1:0];
        if (irst) begin                           // dut is in reset at this edge
            model_reset();
            credits = CFG_CREDITS;
        end
        model_push(words);
        samp      <= words;
        irst      <= rst_req;
        cfg_valid <= send;
        cfg_word  <= cmd;
        if (send) begin
            credits--;
            model_cmd(cmd);
        end
        @(negedge ipclk);
        if (cfg_credit) begin
            credits++;
            credit_pulses++;
        end
        if (irst || send || cfg_credit || credits != CFG_CREDITS) begin
            quiet = 0;
        end else begin
            quiet++;
        end
        if (quiet >= SETTLE) begin
            check_pxd(name, model_predict(), pxd_in);
        end
    endtask

    task automatic idle(input string name, input int n);
        repeat (n) run_cycle(name, 1'b0, '0);
    endtask

    task automatic end_run();
        $display("errors: data %0d, credit %0d, timeout %0d over %0d data checks",
                 data_errs, credit_errs, timeouts, checks);
        if (data_errs == 0 && credit_errs == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    task automatic send_cmd(input string name, input logic [CMD_W-1:0] cmd);
        int waited;
        waited = 0;
        while (credits == 0 && waited < TIMEOUT) begin
            run_cycle(name, 1'b0, '0);            // hold until a credit comes back
            waited++;
        end
        if (credits == 0) begin
            $display("timeout: no credit came back within %0d cycles in %s", TIMEOUT, name);
            timeouts++;
        end else begin
            run_cycle(name, 1'b1, cmd);
        end
    endtask

    task automatic wait_credits(input string name);
        int waited;
        waited = 0;
        while (credits != CFG_CREDITS && waited < TIMEOUT) begin
            run_cycle(name, 1'b0, '0);
            waited++;
        end
        if (credits != CFG_CREDITS) begin
            $display("timeout: credits did not all return within %0d cycles in %s",
                     TIMEOUT, name);
            timeouts++;
        end
    endtask

    // random lane mask, reserved bits and payload
    function automatic logic [CMD_W-1:0] make_cmd(input cfg_op_t op);
        logic [31:0] r;
        r = $urandom;
        return {op, r[CMD_W-3:0]};
    endfunction

    function automatic cfg_op_t rand_op();
        logic [31:0] r;
        r = $urandom;
        return cfg_op_t'(r[1:0]);
    endfunction

    initial begin
        void'($urandom(32'h5c1f));
        ipclk         = 1'b0;
        irst          = 1'b1;
        cfg_valid     = 1'b0;
        cfg_word      = '0;
        samp          = '0;
        rst_req       = 1'b1;
        credits       = CFG_CREDITS;
        credit_pulses = 0;
        quiet         = 0;
        checks        = 0;
        data_errs     = 0;
        credit_errs   = 0;
        timeouts      = 0;
        model_reset();
        run_cycle("reset", 1'b0, '0);
        rst_req = 1'b0;

        // taps and quadrants at zero with no credit traffic
        credit_pulses = 0;
        idle("idle_after_reset", 24);
        check_credits("idle_credit_pulses", 0, credit_pulses);

        repeat (16) begin
            send_cmd("set_quad", make_cmd(OP_SET_QUAD));
            wait_credits("set_quad");
            idle("set_quad", 8);
        end

        // staged tap stays invisible until loaded
        repeat (10) begin
            send_cmd("set_tap", make_cmd(OP_SET_TAP));
            wait_credits("set_tap");
            idle("set_tap_staged", 8);
            send_cmd("ld_tap", make_cmd(OP_LD_TAP));
            wait_credits("ld_tap");
            idle("ld_tap", 8);
        end
        send_cmd("set_tap_max", {OP_SET_TAP, 4'b1111, 6'b0, 4'd15});   // deepest reach
        send_cmd("ld_tap_max", {OP_LD_TAP, 4'b1111, 10'b0});
        wait_credits("ld_tap_max");
        idle("ld_tap_max", 12);

        repeat (6) begin
            credit_pulses = 0;
            repeat (CFG_CREDITS) send_cmd("burst", make_cmd(rand_op()));
            wait_credits("burst");
            check_credits("burst_credit_pulses", CFG_CREDITS, credit_pulses);
            idle("burst", 8);
            check_credits("burst_credit_count", CFG_CREDITS, credits);
        end

        credit_pulses = 0;
        repeat (8) send_cmd("nop", make_cmd(OP_NOP));
        wait_credits("nop");
        idle("nop", 8);
        check_credits("nop_credit_pulses", 8, credit_pulses);

        // mixed traffic with random gaps
        repeat (40) begin
            send_cmd("random_cmd", make_cmd(rand_op()));
            idle("random_cmd", $urandom % 6);
        end
        wait_credits("random_cmd");
        idle("random_cmd", 8);

        // nonzero state right before the second reset
        send_cmd("pre_reset_quad", {OP_SET_QUAD, 4'b1111, 8'b0, 2'd2});
        wait_credits("pre_reset_quad");
        idle("pre_reset_quad", 8);
        rst_req = 1'b1;
        run_cycle("mid_reset", 1'b0, '0);
        run_cycle("mid_reset", 1'b0, '0);
        rst_req       = 1'b0;
        credit_pulses = 0;
        idle("after_mid_reset", 24);
        check_credits("mid_reset_credit_pulses", 0, credit_pulses);
        check_credits("mid_reset_credit_count", CFG_CREDITS, credits);
        end_run();
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+tests
design/sens_pkg.sv
design/pxd_cfg_if.sv
design/pxd_delay_line.sv
design/pxd_lane.sv
design/pxd_dly_ctrl.sv
design/sens_pxd_in.sv
tests/tb_sens_pxd_in.sv

/* Makefile */
# Verilator build and run for the sensor pixel data input testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_sens_pxd_in
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Result: FAILED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	    echo "test failed, see $(LOG)"; exit 1; \
	fi
	@echo "test done, see $(LOG)"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
